/* sources.f */
+incdir+verilog
verilog/clic_csr_pkg.sv
verilog/clic_irq_pkg.sv
verilog/clic_csr_reg.sv
verilog/clic_csr_bank.sv
verilog/clic_prio_arbiter.sv
verilog/clic_dispatch.sv
verilog/clic_top.sv
dv/clic_asserts.sv
dv/clic_tb.sv

/* run.sh */
#!/bin/sh
# build and run the clic testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --assert -f sources.f --top-module clic_tb -o Vclic_tb
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

out=$(./obj_dir/Vclic_tb)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -q "All tests passed"; then
  exit 0
fi
exit 1

/* dv/clic_tb.sv */
// clic testbench with clock, reset, stimulus, reference model, compare tasks and report
`timescale 1ns/1ps
`include "clic_params.svh"

module clic_tb;

  localparam int N = `CLIC_VEC_SIZE;

  logic clk, rst_n, csr_enable, credit_return;
  clic_csr_pkg::csr_addr_t csr_addr;
  clic_csr_pkg::csr_op_t   csr_op;
  clic_csr_pkg::word       rs1_data, csr_rdata;
  clic_csr_pkg::zimm_t     rs1_zimm;
  logic [N-1:0]            irq_lines;
  logic                    irq_valid;
  clic_irq_pkg::vec_idx_t  irq_vec;
  clic_irq_pkg::target_t   irq_target;
  clic_irq_pkg::prio_t     irq_prio;

  // shadow registers
  clic_csr_pkg::word                       sh_mstatus;
  clic_irq_pkg::prio_t                     sh_thresh;
  clic_irq_pkg::target_t [N-1:0]           sh_target;
  clic_irq_pkg::entry_t [N-1:0]            sh_entry;

  int errors, checks, tests, test_errs, beats, returns;
  bit model_on;
  clic_irq_pkg::vec_idx_t beat_vec[$];

  clic_top UUT (
    .clk, .rst_n, .csr_enable, .csr_addr, .csr_op, .rs1_data, .rs1_zimm,
    .irq_lines, .credit_return, .csr_rdata, .irq_valid, .irq_vec, .irq_target, .irq_prio
  );

  bind clic_dispatch clic_asserts #(.CREDIT_W($clog2(`CLIC_IRQ_CREDITS + 1))) u_asserts (
    .clk(clk), .rst_n(rst_n), .irq_valid(irq_valid),
    .credit_return(credit_return), .credits(credits)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // csr op result truncated to the register width
  function automatic clic_csr_pkg::word apply_op(clic_csr_pkg::word old,
      clic_csr_pkg::csr_op_t op, clic_csr_pkg::word data, clic_csr_pkg::zimm_t zimm, int width);
    clic_csr_pkg::word src, res, mask;
    mask = (width >= 32) ? 32'hffff_ffff : ((32'd1 << width) - 32'd1);
    src = (op inside {clic_csr_pkg::CSR_WRITE_IMM, clic_csr_pkg::CSR_SET_IMM,
                      clic_csr_pkg::CSR_CLEAR_IMM}) ? clic_csr_pkg::word'(zimm) : data;
    case (op)
      clic_csr_pkg::CSR_WRITE, clic_csr_pkg::CSR_WRITE_IMM: res = src;
      clic_csr_pkg::CSR_SET, clic_csr_pkg::CSR_SET_IMM: res = old | src;
      clic_csr_pkg::CSR_CLEAR, clic_csr_pkg::CSR_CLEAR_IMM: res = old & ~src;
      default: res = old;
    endcase
    return res & mask;
  endfunction

  function automatic clic_csr_pkg::word expected_read(int addr);
    if (addr == `CLIC_MSTATUS_ADDR) return sh_mstatus;
    if (addr == `CLIC_MINTTHRESH_ADDR) return clic_csr_pkg::word'(sh_thresh);
    if (addr == `CLIC_STACK_DEPTH_ADDR) return `CLIC_STACK_DEPTH_RESET;
    for (int k = 0; k < N; k++) begin
      if (addr == `CLIC_VEC_CSR_BASE + k) return clic_csr_pkg::word'(sh_target[k]);
      if (addr == `CLIC_ENTRY_CSR_BASE + k) return clic_csr_pkg::word'(sh_entry[k]);
    end
    return '0;
  endfunction

  // highest prio and lowest index on a tie, strictly above thresh and only with MIE set
  // -1 when nothing is eligible
  function automatic int expected_winner(clic_irq_pkg::entry_t [N-1:0] e,
      clic_irq_pkg::prio_t th, logic mie);
    int best;
    best = -1;
    for (int i = 0; i < N; i++) begin
      if (e[i].pended && e[i].enable && (best < 0 || e[i].prio > e[best].prio)) best = i;
    end
    if (best >= 0 && (!mie || e[best].prio <= th)) best = -1;
    return best;
  endfunction

  task automatic check_word(string name, clic_csr_pkg::word exp, clic_csr_pkg::word act);
    checks++;
    if (exp !== act) begin
      errors++;
      test_errs++;
      $display("FAIL %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic check_vec(string name, clic_irq_pkg::vec_idx_t exp,
      clic_irq_pkg::vec_idx_t act);
    checks++;
    if (exp !== act) begin
      errors++;
      test_errs++;
      $display("FAIL %s: expected %0d, actual %0d", name, exp, act);
    end
  endtask

  task automatic report_error(string msg);
    errors++;
    test_errs++;
    $display("ERROR: %s", msg);
  endtask

  task automatic finish_test(string name);
    tests++;
    $display("test %s done, %0d errors", name, test_errs);
    test_errs = 0;
  endtask

  // one-cycle access with the shadow updated after the edge that applies it
  task automatic csr_access(clic_csr_pkg::csr_op_t op, int addr, clic_csr_pkg::word data,
      clic_csr_pkg::zimm_t zimm);
    @(posedge clk);
    #1;
    csr_enable = 1'b1;
    csr_op     = op;
    csr_addr   = clic_csr_pkg::csr_addr_t'(addr);
    rs1_data   = data;
    rs1_zimm   = zimm;
    @(posedge clk);
    #1;
    csr_enable = 1'b0;
    csr_op     = clic_csr_pkg::CSR_NONE;
    if (addr == `CLIC_MSTATUS_ADDR) sh_mstatus = apply_op(sh_mstatus, op, data, zimm, 32);
    if (addr == `CLIC_MINTTHRESH_ADDR)
      sh_thresh = clic_irq_pkg::prio_t'(apply_op(sh_thresh, op, data, zimm, 3));
    for (int k = 0; k < N; k++) begin
      if (addr == `CLIC_VEC_CSR_BASE + k)
        sh_target[k] = clic_irq_pkg::target_t'(apply_op(sh_target[k], op, data, zimm, 30));
      if (addr == `CLIC_ENTRY_CSR_BASE + k)
        sh_entry[k] = clic_irq_pkg::entry_t'(apply_op(sh_entry[k], op, data, zimm, 5));
    end
  endtask

  task automatic check_read(string name, int addr);
    @(posedge clk);
    #1;
    csr_addr = clic_csr_pkg::csr_addr_t'(addr);
    @(negedge clk);
    check_word(name, expected_read(addr), csr_rdata);
  endtask

  task automatic op_and_check(string name, clic_csr_pkg::csr_op_t op, int addr,
      clic_csr_pkg::word data, clic_csr_pkg::zimm_t zimm);
    csr_access(op, addr, data, zimm);
    check_read(name, addr);
  endtask

  task automatic wait_beats(int target, int limit);
    int n;
    n = 0;
    while (beats < target && n < limit) begin
      @(posedge clk);
      n++;
    end
    if (beats < target) report_error("no dispatch arrived before the timeout");
  endtask

  task automatic idle(int n);
    repeat (n) @(posedge clk);
  endtask

  task automatic return_credit();
    @(posedge clk);
    #1;
    credit_return = 1'b1;
    @(posedge clk);
    #1;
    credit_return = 1'b0;
    returns++;
  endtask

  task automatic return_all();
    int n;
    n = 0;
    while (returns < beats && n < 16) begin
      return_credit();
      n++;
    end
    if (returns < beats) report_error("outstanding credits never drained");
  endtask

  // records every beat and compares it with the reference winner
  initial begin : monitor
    int w;
    forever begin
      @(negedge clk);
      if (rst_n && irq_valid) begin
        beats++;
        beat_vec.push_back(irq_vec);
        if (model_on) begin
          w = expected_winner(sh_entry, sh_thresh, sh_mstatus[3]);
          if (w < 0) begin
            report_error("dispatch while no entry was eligible");
          end else begin
            check_vec("dispatch vector", clic_irq_pkg::vec_idx_t'(w), irq_vec);
            check_word("dispatch target", sh_target[w], irq_target);
            check_word("dispatch priority", clic_csr_pkg::word'(sh_entry[w].prio),
                       clic_csr_pkg::word'(irq_prio));
            sh_entry[w].pended = 1'b0;
          end
        end
      end
    end
  end

  initial begin : stimulus
    int base, cnt, w;
    clic_irq_pkg::entry_t [N-1:0] copy;
    void'($urandom(32'hd4b6_00ef));
    rst_n = 1'b0;
    csr_enable = 1'b0;
    csr_addr = '0;
    csr_op = clic_csr_pkg::CSR_NONE;
    rs1_data = '0;
    rs1_zimm = '0;
    irq_lines = '0;
    credit_return = 1'b0;
    sh_mstatus = '0;
    sh_thresh = '0;
    sh_target = '0;
    sh_entry = '0;
    model_on = 1'b1;
    repeat (8) @(posedge clk);
    #1;
    rst_n = 1'b1;

    // csr access forms
    check_read("stack_depth reset", `CLIC_STACK_DEPTH_ADDR);
    op_and_check("thresh write", clic_csr_pkg::CSR_WRITE, `CLIC_MINTTHRESH_ADDR, 5, 0);
    op_and_check("thresh set_imm", clic_csr_pkg::CSR_SET_IMM, `CLIC_MINTTHRESH_ADDR, 0, 2);
    op_and_check("thresh clear", clic_csr_pkg::CSR_CLEAR, `CLIC_MINTTHRESH_ADDR, 4, 0);
    op_and_check("mstatus write", clic_csr_pkg::CSR_WRITE, `CLIC_MSTATUS_ADDR, 32'h1234_5670, 0);
    op_and_check("mstatus set", clic_csr_pkg::CSR_SET, `CLIC_MSTATUS_ADDR, 32'h100, 0);
    op_and_check("mstatus clear_imm", clic_csr_pkg::CSR_CLEAR_IMM, `CLIC_MSTATUS_ADDR, 0, 5'h10);
    op_and_check("mstatus write_imm", clic_csr_pkg::CSR_WRITE_IMM, `CLIC_MSTATUS_ADDR, 0, 5'h07);
    op_and_check("target write", clic_csr_pkg::CSR_WRITE, `CLIC_VEC_CSR_BASE + 2, '1, 0);
    op_and_check("target clear_imm", clic_csr_pkg::CSR_CLEAR_IMM,
                 `CLIC_VEC_CSR_BASE + 2, 0, 5'h1f);
    op_and_check("entry write_imm", clic_csr_pkg::CSR_WRITE_IMM,
                 `CLIC_ENTRY_CSR_BASE + 5, 0, 5'h1f);
    op_and_check("entry clear", clic_csr_pkg::CSR_CLEAR, `CLIC_ENTRY_CSR_BASE + 5, 32'h08, 0);
    op_and_check("entry set_imm", clic_csr_pkg::CSR_SET_IMM, `CLIC_ENTRY_CSR_BASE + 5, 0, 5'h0a);
    op_and_check("stack_depth write", clic_csr_pkg::CSR_WRITE, `CLIC_STACK_DEPTH_ADDR, 0, 0);
    op_and_check("unmapped", clic_csr_pkg::CSR_WRITE, 'h123, 32'hdead_beef, 0);
    csr_access(clic_csr_pkg::CSR_WRITE, `CLIC_ENTRY_CSR_BASE + 5, 0, 0);
    csr_access(clic_csr_pkg::CSR_WRITE, `CLIC_MSTATUS_ADDR, 0, 0);
    csr_access(clic_csr_pkg::CSR_WRITE, `CLIC_MINTTHRESH_ADDR, 0, 0);
    finish_test("csr_access");

    // single dispatch from a software pend
    csr_access(clic_csr_pkg::CSR_WRITE, `CLIC_VEC_CSR_BASE + 3, 32'h0abc_def0, 0);
    csr_access(clic_csr_pkg::CSR_SET_IMM, `CLIC_MSTATUS_ADDR, 0, 5'h08);
    base = beats;
    csr_access(clic_csr_pkg::CSR_WRITE_IMM, `CLIC_ENTRY_CSR_BASE + 3, 0, 5'h1d);
    wait_beats(base + 1, 20);
    if (beats > base) check_vec("single vector", 3, beat_vec[$]);
    check_read("entry after dispatch", `CLIC_ENTRY_CSR_BASE + 3);
    return_all();
    csr_access(clic_csr_pkg::CSR_WRITE, `CLIC_ENTRY_CSR_BASE + 3, 0, 0);
    finish_test("single_dispatch");

    // random arbitration with vectors 1 and 5 tied across the halves
    csr_access(clic_csr_pkg::CSR_WRITE, `CLIC_MSTATUS_ADDR, 0, 0);
    csr_access(clic_csr_pkg::CSR_WRITE, `CLIC_MINTTHRESH_ADDR, 1, 0);
    for (int k = 0; k < N; k++) begin
      csr_access(clic_csr_pkg::CSR_WRITE, `CLIC_VEC_CSR_BASE + k, $urandom, 0);
      w = (k == 1 || k == 5) ? 5'h1e : 5'($urandom_range(31, 0));
      csr_access(clic_csr_pkg::CSR_WRITE, `CLIC_ENTRY_CSR_BASE + k, w, 0);
    end
    copy = sh_entry;
    cnt = 0;
    w = expected_winner(copy, sh_thresh, 1'b1);
    while (w >= 0) begin
      copy[w].pended = 1'b0;
      cnt++;
      w = expected_winner(copy, sh_thresh, 1'b1);
    end
    base = beats;
    csr_access(clic_csr_pkg::CSR_SET_IMM, `CLIC_MSTATUS_ADDR, 0, 5'h08);
    for (int i = 0; i < cnt; i++) begin
      wait_beats(base + i + 1, 20);
      return_credit();
    end
    idle(20);
    check_word("arbitration count", cnt, beats - base);
    return_all();
    csr_access(clic_csr_pkg::CSR_WRITE, `CLIC_MSTATUS_ADDR, 0, 0);
    for (int k = 0; k < N; k++) begin
      csr_access(clic_csr_pkg::CSR_WRITE, `CLIC_ENTRY_CSR_BASE + k, 0, 0);
    end
    finish_test("arbitration");

    // threshold, enable and MIE gating
    csr_access(clic_csr_pkg::CSR_WRITE, `CLIC_MINTTHRESH_ADDR, 3, 0);
    csr_access(clic_csr_pkg::CSR_SET_IMM, `CLIC_MSTATUS_ADDR, 0, 5'h08);
    base = beats;
    csr_access(clic_csr_pkg::CSR_WRITE_IMM, `CLIC_ENTRY_CSR_BASE + 0, 0, 5'h1b);
    csr_access(clic_csr_pkg::CSR_WRITE_IMM, `CLIC_ENTRY_CSR_BASE + 1, 0, 5'h16);
    idle(20);
    check_word("no issue at threshold or disabled", 0, beats - base);
    csr_access(clic_csr_pkg::CSR_CLEAR_IMM, `CLIC_MSTATUS_ADDR, 0, 5'h08);
    csr_access(clic_csr_pkg::CSR_WRITE_IMM, `CLIC_ENTRY_CSR_BASE + 2, 0, 5'h1d);
    idle(20);
    check_word("no issue with MIE clear", 0, beats - base);
    csr_access(clic_csr_pkg::CSR_SET_IMM, `CLIC_MSTATUS_ADDR, 0, 5'h08);
    wait_beats(base + 1, 20);
    idle(20);
    check_word("single release", 1, beats - base);
    return_all();
    csr_access(clic_csr_pkg::CSR_WRITE, `CLIC_MSTATUS_ADDR, 0, 0);
    for (int k = 0; k < 3; k++) begin
      csr_access(clic_csr_pkg::CSR_WRITE, `CLIC_ENTRY_CSR_BASE + k, 0, 0);
    end
    csr_access(clic_csr_pkg::CSR_WRITE, `CLIC_MINTTHRESH_ADDR, 0, 0);
    finish_test("gating");

    // credit back-pressure
    for (int k = 0; k < 4; k++)
      csr_access(clic_csr_pkg::CSR_WRITE_IMM, `CLIC_ENTRY_CSR_BASE + 2 * k + 1, 0, 5'(31 - k));
    base = beats;
    csr_access(clic_csr_pkg::CSR_SET_IMM, `CLIC_MSTATUS_ADDR, 0, 5'h08);
    wait_beats(base + `CLIC_IRQ_CREDITS, 20);
    idle(20);
    check_word("issues without credit return", `CLIC_IRQ_CREDITS, beats - base);
    check_read("still pended", `CLIC_ENTRY_CSR_BASE + 5);
    check_read("still pended", `CLIC_ENTRY_CSR_BASE + 7);
    for (int i = 1; i <= 2; i++) begin
      return_credit();
      wait_beats(base + `CLIC_IRQ_CREDITS + i, 20);
      idle(10);
      check_word("issue per credit return", `CLIC_IRQ_CREDITS + i, beats - base);
    end
    return_all();
    csr_access(clic_csr_pkg::CSR_WRITE, `CLIC_MSTATUS_ADDR, 0, 0);
    finish_test("credits");

    // hardware lines pulsed then held
    model_on = 1'b0;
    csr_access(clic_csr_pkg::CSR_WRITE_IMM, `CLIC_ENTRY_CSR_BASE + 6, 0, 5'h0c);
    csr_access(clic_csr_pkg::CSR_SET_IMM, `CLIC_MSTATUS_ADDR, 0, 5'h08);
    base = beats;
    @(posedge clk);
    #1;
    irq_lines[6] = 1'b1;
    @(posedge clk);
    #1;
    irq_lines[6] = 1'b0;
    wait_beats(base + 1, 20);
    if (beats > base) check_vec("line pulse vector", 6, beat_vec[$]);
    idle(10);
    return_all();
    @(posedge clk);
    #1;
    irq_lines[6] = 1'b1;
    for (int i = 0; i < 3; i++) begin
      base = beats;
      wait_beats(base + 1, 20);
      if (beats > base) check_vec("held line vector", 6, beat_vec[$]);
      return_credit();
    end
    @(posedge clk);
    #1;
    irq_lines[6] = 1'b0;
    idle(10);
    return_all();
    idle(10);
    return_all();
    csr_access(clic_csr_pkg::CSR_WRITE, `CLIC_MSTATUS_ADDR, 0, 0);
    finish_test("hw_lines");

    $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
    if (errors == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

/* dv/clic_asserts.sv */
// concurrent checks on clic dispatch beats against the credit rules
`timescale 1ns/1ps
`include "clic_params.svh"

module clic_asserts #(
  parameter int CREDIT_W = 2
) (
  input logic                clk,
  input logic                rst_n,
  input logic                irq_valid,
  input logic                credit_return,
  input logic [CREDIT_W-1:0] credits
);

  // beats seen by the core minus credits handed back
  int outstanding;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      outstanding <= 0;
    end else begin
      outstanding <= outstanding + int'(irq_valid) - int'(credit_return);
    end
  end

  // a beat in flight has already taken its credit
  a_no_issue_at_zero: assert property (@(posedge clk) disable iff (!rst_n)
    outstanding + int'(irq_valid) <= `CLIC_IRQ_CREDITS)
    else $error("more beats in flight than credits granted");

  // every cycle of irq_valid costs exactly one credit
  // a return gives one back
  a_credit_account: assert property (@(posedge clk) disable iff (!rst_n)
    int'(credits) + outstanding + int'(irq_valid) == `CLIC_IRQ_CREDITS)
    else $error("credit count does not match beats and returns");

  a_credit_bound: assert property (@(posedge clk) disable iff (!rst_n)
    credits <= CREDIT_W'(`CLIC_IRQ_CREDITS)) else $error("credit count above limit");

endmodule

/* verilog/clic_top.sv */
// clic top level with csr bank, two slice arbiters and dispatch
`timescale 1ns/1ps
`include "clic_params.svh"

module clic_top (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic                          csr_enable,
  input  clic_csr_pkg::csr_addr_t       csr_addr,
  input  clic_csr_pkg::csr_op_t         csr_op,
  input  clic_csr_pkg::word             rs1_data,
  input  clic_csr_pkg::zimm_t           rs1_zimm,
  input  logic [`CLIC_VEC_SIZE-1:0]     irq_lines,
  input  logic                          credit_return,
  output clic_csr_pkg::word             csr_rdata,
  output logic                          irq_valid,
  output clic_irq_pkg::vec_idx_t        irq_vec,
  output clic_irq_pkg::target_t         irq_target,
  output clic_irq_pkg::prio_t           irq_prio
);

  localparam int HALF = `CLIC_VEC_SIZE / 2;

  // bank to arbiters
  logic [`CLIC_VEC_SIZE-1:0]                  pended;
  logic [`CLIC_VEC_SIZE-1:0]                  enable;
  clic_irq_pkg::prio_t [`CLIC_VEC_SIZE-1:0]   prio;

  // bank to dispatch
  clic_irq_pkg::target_t [`CLIC_VEC_SIZE-1:0] targets;
  clic_irq_pkg::prio_t                        thresh;
  logic                                       mie;

  // arbiters to dispatch
  logic                   found_lo;
  clic_irq_pkg::vec_idx_t vec_lo;
  clic_irq_pkg::prio_t    prio_lo;
  logic                   found_hi;
  clic_irq_pkg::vec_idx_t vec_hi;
  clic_irq_pkg::prio_t    prio_hi;

  // dispatch back to bank
  logic                   clear_valid;
  clic_irq_pkg::vec_idx_t clear_vec;

  clic_csr_bank u_bank (
    .clk, .rst_n, .csr_enable, .csr_addr, .csr_op, .rs1_data, .rs1_zimm,
    .irq_lines, .clear_valid, .clear_vec,
    .csr_rdata, .pended, .enable, .prio, .targets, .thresh, .mie
  );

  // vectors 0 to 3
  clic_prio_arbiter #(.NUM(HALF), .BASE(0)) u_arb_lo (
    .pended(pended[HALF-1:0]), .enable(enable[HALF-1:0]), .prio(prio[HALF-1:0]),
    .found(found_lo), .vec(vec_lo), .prio_out(prio_lo)
  );

  // vectors 4 to 7
  clic_prio_arbiter #(.NUM(HALF), .BASE(HALF)) u_arb_hi (
    .pended(pended[`CLIC_VEC_SIZE-1:HALF]), .enable(enable[`CLIC_VEC_SIZE-1:HALF]),
    .prio(prio[`CLIC_VEC_SIZE-1:HALF]),
    .found(found_hi), .vec(vec_hi), .prio_out(prio_hi)
  );

  clic_dispatch u_dispatch (
    .clk, .rst_n,
    .found_lo, .vec_lo, .prio_lo, .found_hi, .vec_hi, .prio_hi,
    .thresh, .mie, .targets, .credit_return,
    .irq_valid, .irq_vec, .irq_target, .irq_prio, .clear_valid, .clear_vec
  );

endmodule

/* verilog/clic_dispatch.sv */
// clic dispatch with slice merge, threshold and MIE gating, and credit counter
`timescale 1ns/1ps
`include "clic_params.svh"

module clic_dispatch (
  input  logic                                       clk,
  input  logic                                       rst_n,
  input  logic                                       found_lo,
  input  clic_irq_pkg::vec_idx_t                     vec_lo,
  input  clic_irq_pkg::prio_t                        prio_lo,
  input  logic                                       found_hi,
  input  clic_irq_pkg::vec_idx_t                     vec_hi,
  input  clic_irq_pkg::prio_t                        prio_hi,
  input  clic_irq_pkg::prio_t                        thresh,
  input  logic                                       mie,
  input  clic_irq_pkg::target_t [`CLIC_VEC_SIZE-1:0] targets,
  input  logic                                       credit_return,
  output logic                                       irq_valid,
  output clic_irq_pkg::vec_idx_t                     irq_vec,
  output clic_irq_pkg::target_t                      irq_target,
  output clic_irq_pkg::prio_t                        irq_prio,
  output logic                                       clear_valid,
  output clic_irq_pkg::vec_idx_t                     clear_vec
);

  localparam int CREDIT_W = $clog2(`CLIC_IRQ_CREDITS + 1);

  logic                   sel_hi;
  logic                   win_found;
  clic_irq_pkg::vec_idx_t win_vec;
  clic_irq_pkg::prio_t    win_prio;
  logic                   issue;
  logic [CREDIT_W-1:0]    credits;

  // upper slice only on a strictly higher level
  assign sel_hi    = found_hi && (!found_lo || (prio_hi > prio_lo));
  assign win_found = found_lo || found_hi;
  assign win_vec   = sel_hi ? vec_hi : vec_lo;
  assign win_prio  = sel_hi ? prio_hi : prio_lo;

  // registered credit count only, a return this cycle does not count yet
  assign issue = win_found && (win_prio > thresh) && mie && (credits != '0);

  // clears the pended bit on the same edge the issue is registered
  assign clear_valid = issue;
  assign clear_vec   = win_vec;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      irq_valid <= 1'b0;
    end else begin
      irq_valid <= issue;
    end
  end

  // payload held until the next issue
  always_ff @(posedge clk) begin
    if (issue) begin
      irq_vec    <= win_vec;
      irq_target <= targets[win_vec];
      irq_prio   <= win_prio;
    end
  end

  // return and issue together leave the count unchanged
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      credits <= CREDIT_W'(`CLIC_IRQ_CREDITS);
    end else if (issue && !credit_return) begin
      credits <= credits - 1'b1;
    end else if (!issue && credit_return) begin
      credits <= credits + 1'b1;
    end
  end

endmodule

/* verilog/clic_prio_arbiter.sv */
// priority arbiter over one slice of interrupt vectors
`timescale 1ns/1ps

module clic_prio_arbiter #(
  parameter int NUM  = 4,
  parameter int BASE = 0
) (
  input  logic [NUM-1:0]                pended,
  input  logic [NUM-1:0]                enable,
  input  clic_irq_pkg::prio_t [NUM-1:0] prio,
  output logic                          found,
  output clic_irq_pkg::vec_idx_t        vec,
  output clic_irq_pkg::prio_t           prio_out
);

  logic                   any;
  clic_irq_pkg::prio_t    best_prio;
  clic_irq_pkg::vec_idx_t best_vec;

  // linear scan from the lowest index
  // strict compare keeps the lower index on a tie
  always_comb begin
    any       = 1'b0;
    best_prio = '0;
    best_vec  = clic_irq_pkg::vec_idx_t'(BASE);
    for (int i = 0; i < NUM; i++) begin
      if (pended[i] && enable[i] && (!any || (prio[i] > best_prio))) begin
        any       = 1'b1;
        best_prio = prio[i];
        // global vector number
        best_vec  = clic_irq_pkg::vec_idx_t'(BASE + i);
      end
    end
  end

  assign found    = any;
  assign vec      = best_vec;
  assign prio_out = best_prio;

endmodule

/* verilog/clic_csr_bank.sv */
// clic csr instances, pended-bit update and csr read mux
`timescale 1ns/1ps
`include "clic_params.svh"

module clic_csr_bank (
  input  logic                                       clk,
  input  logic                                       rst_n,
  input  logic                                       csr_enable,
  input  clic_csr_pkg::csr_addr_t                    csr_addr,
  input  clic_csr_pkg::csr_op_t                      csr_op,
  input  clic_csr_pkg::word                          rs1_data,
  input  clic_csr_pkg::zimm_t                        rs1_zimm,
  input  logic [`CLIC_VEC_SIZE-1:0]                  irq_lines,
  input  logic                                       clear_valid,
  input  clic_irq_pkg::vec_idx_t                     clear_vec,
  output clic_csr_pkg::word                          csr_rdata,
  output logic [`CLIC_VEC_SIZE-1:0]                  pended,
  output logic [`CLIC_VEC_SIZE-1:0]                  enable,
  output clic_irq_pkg::prio_t [`CLIC_VEC_SIZE-1:0]   prio,
  output clic_irq_pkg::target_t [`CLIC_VEC_SIZE-1:0] targets,
  output clic_irq_pkg::prio_t                        thresh,
  output logic                                       mie
);

  // one bit wider than a vector index so a depth of 8 fits
  typedef logic [`CLIC_VEC_WIDTH:0] depth_t;

  clic_csr_pkg::word                        mstatus;
  depth_t                                   stack_depth;
  clic_irq_pkg::entry_t [`CLIC_VEC_SIZE-1:0] entries;

  clic_csr_reg #(
    .data_t(clic_irq_pkg::prio_t),
    .ADDR(clic_csr_pkg::csr_addr_t'(`CLIC_MINTTHRESH_ADDR))
  ) u_thresh (
    .clk, .rst_n, .csr_enable, .csr_addr, .csr_op, .rs1_data, .rs1_zimm,
    .hw_we(1'b0), .hw_data('0), .data(thresh)
  );

  clic_csr_reg #(
    .data_t(clic_csr_pkg::word),
    .ADDR(clic_csr_pkg::csr_addr_t'(`CLIC_MSTATUS_ADDR))
  ) u_mstatus (
    .clk, .rst_n, .csr_enable, .csr_addr, .csr_op, .rs1_data, .rs1_zimm,
    .hw_we(1'b0), .hw_data('0), .data(mstatus)
  );

  // fixed value, software writes ignored
  clic_csr_reg #(
    .data_t(depth_t),
    .ADDR(clic_csr_pkg::csr_addr_t'(`CLIC_STACK_DEPTH_ADDR)),
    .RESET_VALUE(depth_t'(`CLIC_STACK_DEPTH_RESET)),
    .WRITABLE(1'b0)
  ) u_stack_depth (
    .clk, .rst_n, .csr_enable, .csr_addr, .csr_op, .rs1_data, .rs1_zimm,
    .hw_we(1'b0), .hw_data('0), .data(stack_depth)
  );

  // only MIE is used
  assign mie = mstatus[3];

  for (genvar k = 0; k < `CLIC_VEC_SIZE; k++) begin : gen_vec
    logic                 clear_hit;
    logic                 upd_we;
    clic_irq_pkg::entry_t upd;

    // dispatch clear wins over a line set
    // held line pends again on the next edge
    assign clear_hit = clear_valid && (clear_vec == clic_irq_pkg::vec_idx_t'(k));
    assign upd_we    = clear_hit || irq_lines[k];
    assign upd       = '{pended: !clear_hit, enable: entries[k].enable, prio: entries[k].prio};

    clic_csr_reg #(
      .data_t(clic_irq_pkg::target_t),
      .ADDR(clic_csr_pkg::csr_addr_t'(`CLIC_VEC_CSR_BASE + k))
    ) u_target (
      .clk, .rst_n, .csr_enable, .csr_addr, .csr_op, .rs1_data, .rs1_zimm,
      .hw_we(1'b0), .hw_data('0), .data(targets[k])
    );

    clic_csr_reg #(
      .data_t(clic_irq_pkg::entry_t),
      .ADDR(clic_csr_pkg::csr_addr_t'(`CLIC_ENTRY_CSR_BASE + k))
    ) u_entry (
      .clk, .rst_n, .csr_enable, .csr_addr, .csr_op, .rs1_data, .rs1_zimm,
      .hw_we(upd_we), .hw_data(upd), .data(entries[k])
    );

    // split fields for the arbiters
    assign pended[k] = entries[k].pended;
    assign enable[k] = entries[k].enable;
    assign prio[k]   = entries[k].prio;
  end

  // combinational read, unmapped reads as zero
  always_comb begin
    csr_rdata = '0;
    if (csr_addr == clic_csr_pkg::csr_addr_t'(`CLIC_MSTATUS_ADDR)) begin
      csr_rdata = mstatus;
    end else if (csr_addr == clic_csr_pkg::csr_addr_t'(`CLIC_MINTTHRESH_ADDR)) begin
      csr_rdata = clic_csr_pkg::word'(thresh);
    end else if (csr_addr == clic_csr_pkg::csr_addr_t'(`CLIC_STACK_DEPTH_ADDR)) begin
      csr_rdata = clic_csr_pkg::word'(stack_depth);
    end else begin
      for (int k = 0; k < `CLIC_VEC_SIZE; k++) begin
        if (csr_addr == clic_csr_pkg::csr_addr_t'(`CLIC_VEC_CSR_BASE + k)) begin
          csr_rdata = clic_csr_pkg::word'(targets[k]);
        end else if (csr_addr == clic_csr_pkg::csr_addr_t'(`CLIC_ENTRY_CSR_BASE + k)) begin
          csr_rdata = clic_csr_pkg::word'(entries[k]);
        end
      end
    end
  end

endmodule

/* verilog/clic_csr_reg.sv */
// generic csr register with software ops and a hardware update port
`timescale 1ns/1ps

module clic_csr_reg #(
  parameter type data_t = logic [31:0],
  parameter clic_csr_pkg::csr_addr_t ADDR = '0,
  parameter data_t RESET_VALUE = '0,
  parameter bit WRITABLE = 1'b1
) (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     csr_enable,
  input  clic_csr_pkg::csr_addr_t  csr_addr,
  input  clic_csr_pkg::csr_op_t    csr_op,
  input  clic_csr_pkg::word        rs1_data,
  input  clic_csr_pkg::zimm_t      rs1_zimm,
  input  logic                     hw_we,
  input  data_t                    hw_data,
  output data_t                    data
);

  localparam int W = $bits(data_t);

  logic         hit;
  logic [W-1:0] src;
  logic [W-1:0] cur;
  logic [W-1:0] sw_val;

  // own address decode, read-only copies never match
  assign hit = WRITABLE && csr_enable && (csr_addr == ADDR);
  assign cur = data;

  // operand select, immediates are zero extended
  always_comb begin
    case (csr_op)
      clic_csr_pkg::CSR_WRITE_IMM,
      clic_csr_pkg::CSR_SET_IMM,
      clic_csr_pkg::CSR_CLEAR_IMM: src = W'(rs1_zimm);
      default: src = W'(rs1_data);
    endcase
  end

  // read-modify-write result
  always_comb begin
    case (csr_op)
      clic_csr_pkg::CSR_WRITE, clic_csr_pkg::CSR_WRITE_IMM: sw_val = src;
      clic_csr_pkg::CSR_SET, clic_csr_pkg::CSR_SET_IMM: sw_val = cur | src;
      clic_csr_pkg::CSR_CLEAR, clic_csr_pkg::CSR_CLEAR_IMM: sw_val = cur & ~src;
      default: sw_val = cur;
    endcase
  end

  // hardware update beats software on the same edge
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      data <= RESET_VALUE;
    end else if (hw_we) begin
      data <= hw_data;
    end else if (hit) begin
      data <= data_t'(sw_val);
    end
  end

endmodule

/* verilog/clic_irq_pkg.sv */
// interrupt priority, vector index, handler target and entry types
`include "clic_params.svh"

package clic_irq_pkg;

  // priority level, higher wins
  typedef logic [`CLIC_PRIO_WIDTH-1:0] prio_t;

  // global vector number
  typedef logic [`CLIC_VEC_WIDTH-1:0] vec_idx_t;

  // handler word address
  typedef logic [`CLIC_TARGET_WIDTH-1:0] target_t;

  // per-vector config entry
  // 5 bits total so a single csrrwi can load all fields
  typedef struct packed {
    // waiting for service
    logic  pended;
    // allowed to be taken
    logic  enable;
    // level compared against mintthresh
    prio_t prio;
  } entry_t;

endpackage

/* verilog/clic_csr_pkg.sv */
// csr data word, address, immediate and access operation types
package clic_csr_pkg;

  // data path of the csr stage
  typedef logic [31:0] word;

  // standard 12-bit csr address space
  typedef logic [11:0] csr_addr_t;

  // uimm field of the csrr*i forms
  typedef logic [4:0] zimm_t;

  // access kind decoded by the core
  // set or clear with a zero source is still treated as a write
  typedef enum logic [2:0] {
    // no access this cycle
    CSR_NONE      = 3'd0,
    // csrrw
    CSR_WRITE     = 3'd1,
    // csrrs
    CSR_SET       = 3'd2,
    // csrrc
    CSR_CLEAR     = 3'd3,
    // csrrwi
    CSR_WRITE_IMM = 3'd4,
    // csrrsi
    CSR_SET_IMM   = 3'd5,
    // csrrci
    CSR_CLEAR_IMM = 3'd6
  } csr_op_t;

endpackage

/* verilog/clic_params.svh */
// clic vector count, field widths, csr addresses and dispatch credits
`ifndef CLIC_PARAMS_SVH
`define CLIC_PARAMS_SVH

// number of interrupt vectors
`define CLIC_VEC_SIZE 8

// priority field width
`define CLIC_PRIO_WIDTH 3

// vector index width
`define CLIC_VEC_WIDTH 3

// handler address in 32-bit words
`define CLIC_TARGET_WIDTH 30

// per-vector csr windows
`define CLIC_VEC_CSR_BASE 'hb00
`define CLIC_ENTRY_CSR_BASE 'hb20

// single machine-level csrs
`define CLIC_MSTATUS_ADDR 'h300
`define CLIC_MINTTHRESH_ADDR 'h347
`define CLIC_STACK_DEPTH_ADDR 'h350

// read-only depth reported after reset
`define CLIC_STACK_DEPTH_RESET 8

// interrupts the core can accept before returning credits
`define CLIC_IRQ_CREDITS 2

`endif
